// File: rtl/u1_pkg.sv
//////////////////////////////////////////////////////////////////////
// bus widths, slave slots, register map, bus structs, time union
//////////////////////////////////////////////////////////////////////
package u1_pkg;

   // wishbone geometry
   localparam int DW       = 16;
   localparam int AW       = 11;
   localparam int SW       = 2;
   localparam int DECODE_W = 4;    // top address bits pick the slave

   localparam logic [DECODE_W-1:0] SLV_MISC     = 4'h0;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS = 4'h5;

   // misc block, byte offsets in the low seven address bits
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;    // read only
   localparam logic [6:0] REG_TEST      = 7'd8;

   localparam logic [DW-1:0] UNMAPPED_READ   = 16'hBEEF;
   localparam logic [DW-1:0] CGEN_CTRL_RESET = 16'd3;   // sync_b and ref_sel high

   // settings registers of the timekeeper
   localparam logic [7:0] SR_TIME64 = 8'd28;
   localparam logic [7:0] SR_SECS   = 8'd0;
   localparam logic [7:0] SR_TICKS  = 8'd1;
   localparam logic [7:0] SR_LOAD   = 8'd2;

   typedef struct packed {
      logic [AW-1:0] adr;
      logic [DW-1:0] dat;
      logic [SW-1:0] sel;
      logic          we;
      logic          cyc;
      logic          stb;
   } wb_req_t;

   typedef struct packed {
      logic [DW-1:0] dat;
      logic          ack;
   } wb_rsp_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic status;
      logic ld;
      logic refmon;
   } cgen_st_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_fields_t;

   typedef union packed {
      logic [63:0]  raw;
      vita_fields_t fields;
   } vita_time_u;

endpackage

// File: rtl/wb_decoder.sv
//////////////////////////////////////////////////////////////////////
// single master wishbone decode, two peer slaves, response mux
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_decoder
(
   input  u1_pkg::wb_req_t m_req_i,
   output u1_pkg::wb_rsp_t m_rsp_o,
   output u1_pkg::wb_req_t misc_req_o,
   input  u1_pkg::wb_rsp_t misc_rsp_i,
   output u1_pkg::wb_req_t set_req_o,
   input  u1_pkg::wb_rsp_t set_rsp_i
);

   logic [u1_pkg::DECODE_W-1:0] slot;
   logic                        hit_misc;
   logic                        hit_set;

   assign slot     = m_req_i.adr[u1_pkg::AW-1 -: u1_pkg::DECODE_W];
   assign hit_misc = (slot == u1_pkg::SLV_MISC);
   assign hit_set  = (slot == u1_pkg::SLV_SETTINGS);

   //////////////////////////////////////////////////////////////////////
   // request fan out, only the addressed slave sees the strobe
   always_comb
   begin
      misc_req_o     = m_req_i;
      misc_req_o.cyc = m_req_i.cyc & hit_misc;
      misc_req_o.stb = m_req_i.stb & hit_misc;

      set_req_o      = m_req_i;
      set_req_o.cyc  = m_req_i.cyc & hit_set;
      set_req_o.stb  = m_req_i.stb & hit_set;
   end

   //////////////////////////////////////////////////////////////////////
   // response return
   always_comb
   begin
      case (slot)
         u1_pkg::SLV_MISC:
            m_rsp_o = misc_rsp_i;
         u1_pkg::SLV_SETTINGS:
            m_rsp_o = set_rsp_i;
         default:
            m_rsp_o = '0;     // empty slot, never acks
      endcase
   end

endmodule

// File: rtl/misc_regs.sv
//////////////////////////////////////////////////////////////////////
// slave 0, led / clock generator control / test registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module misc_regs
(
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1_pkg::wb_req_t   req_i,
   output u1_pkg::wb_rsp_t   rsp_o,
   input  u1_pkg::cgen_st_t  cgen_st_i,
   output logic [2:0]        led_o,
   output logic              cgen_sync_b_o,
   output logic              cgen_ref_sel_o
);

   logic [u1_pkg::DW-1:0] reg_leds;
   logic [u1_pkg::DW-1:0] reg_cgen_ctrl;
   logic [u1_pkg::DW-1:0] reg_test;
   logic [6:0]            offs;
   logic                  wr;

   assign offs = req_i.adr[6:0];
   assign wr   = req_i.cyc & req_i.stb & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= u1_pkg::CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (wr)
      begin
         case (offs)
            u1_pkg::REG_LEDS:      reg_leds      <= req_i.dat;
            u1_pkg::REG_CGEN_CTRL: reg_cgen_ctrl <= req_i.dat;
            u1_pkg::REG_TEST:      reg_test      <= req_i.dat;
            default:               ;
         endcase
      end
   end

   // board leds are wired out of order
   assign led_o          = {reg_leds[2], reg_leds[0], reg_leds[1]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   //////////////////////////////////////////////////////////////////////
   // read side, zero wait
   always_comb
   begin
      case (offs)
         u1_pkg::REG_LEDS:      rsp_o.dat = reg_leds;
         u1_pkg::REG_CGEN_CTRL: rsp_o.dat = reg_cgen_ctrl;
         u1_pkg::REG_CGEN_ST:
            rsp_o.dat = {13'd0, cgen_st_i.status, cgen_st_i.ld, cgen_st_i.refmon};
         u1_pkg::REG_TEST:      rsp_o.dat = reg_test;
         default:               rsp_o.dat = u1_pkg::UNMAPPED_READ;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

// File: rtl/settings_bus_16le.sv
//////////////////////////////////////////////////////////////////////
// slave 5, pairs of 16 bit writes into 32 bit settings strobes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module settings_bus_16le
(
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1_pkg::wb_req_t   req_i,
   output u1_pkg::wb_rsp_t   rsp_o,
   output u1_pkg::set_bus_t  set_o
);

   logic [u1_pkg::DW-1:0] low_q;       // low half waiting for its partner
   logic                  wr;
   logic                  wr_low;
   logic                  wr_high;
   logic                  stb_q;
   logic [7:0]            addr_q;
   logic [31:0]           data_q;

   assign wr      = req_i.cyc & req_i.stb & req_i.we;
   assign wr_low  = wr & ~req_i.adr[1];
   assign wr_high = wr &  req_i.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         stb_q <= 1'b0;
      else
         stb_q <= wr_high;    // single cycle, one after the ack
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_q <= req_i.dat;
      if (wr_high)
      begin
         addr_q <= {3'd0, req_i.adr[6:2]};
         data_q <= {req_i.dat, low_q};
      end
   end

   assign set_o.stb  = stb_q;
   assign set_o.addr = addr_q;
   assign set_o.data = data_q;

   // write only
   assign rsp_o.dat = '0;
   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

// File: rtl/time_64bit.sv
//////////////////////////////////////////////////////////////////////
// seconds/ticks timekeeper, immediate or pps-aligned load
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module time_64bit
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd64000000,
   parameter logic [7:0]  BASE          = 8'd0
)
(
   input  logic               wb_clk,
   input  logic               wb_rst,
   input  u1_pkg::set_bus_t   set_i,
   input  logic               pps_i,
   output u1_pkg::vita_time_u vita_time_o,
   output logic               pps_int_o
);

   localparam logic [7:0] ADDR_SECS  = BASE + u1_pkg::SR_SECS;
   localparam logic [7:0] ADDR_TICKS = BASE + u1_pkg::SR_TICKS;
   localparam logic [7:0] ADDR_LOAD  = BASE + u1_pkg::SR_LOAD;

   logic [31:0]        pend_secs;
   logic [31:0]        pend_ticks;
   logic               armed;
   logic               pps_s1;
   logic               pps_s2;
   logic               pps_d;
   logic               pps_edge;
   logic               is_load;
   logic               load_now;
   u1_pkg::vita_time_u now_q;

   assign is_load  = set_i.stb & (set_i.addr == ADDR_LOAD);
   assign pps_edge = pps_s2 & ~pps_d;
   assign load_now = (is_load & set_i.data[0]) | (armed & pps_edge);

   // time waiting to be loaded
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == ADDR_SECS)
         pend_secs <= set_i.data;
      if (set_i.stb && set_i.addr == ADDR_TICKS)
         pend_ticks <= set_i.data;
   end

   //////////////////////////////////////////////////////////////////////
   // pps synchronizer, edge detect and arm flag
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_d     <= 1'b0;
         pps_int_o <= 1'b0;
         armed     <= 1'b0;
      end
      else
      begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_d     <= pps_s2;
         pps_int_o <= pps_edge;    // lines up with a pps load
         if (is_load)
            armed <= ~set_i.data[0];
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // tick counter with rollover into seconds
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         now_q.raw <= '0;
      else if (load_now)
      begin
         now_q.fields.secs  <= pend_secs;   // no tick on the load cycle
         now_q.fields.ticks <= pend_ticks;
      end
      else if (now_q.fields.ticks == TICKS_PER_SEC - 32'd1)
      begin
         now_q.fields.ticks <= '0;
         now_q.fields.secs  <= now_q.fields.secs + 32'd1;
      end
      else
         now_q.fields.ticks <= now_q.fields.ticks + 32'd1;
   end

   assign vita_time_o = now_q;

endmodule

// File: rtl/u1_core.sv
//////////////////////////////////////////////////////////////////////
// control plane top, wishbone decode, slaves and timekeeper
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module u1_core
#(
   parameter logic [31:0] TICKS_PER_SEC = 32'd64000000
)
(
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1_pkg::wb_req_t   wb_req_i,
   output u1_pkg::wb_rsp_t   wb_rsp_o,
   input  u1_pkg::cgen_st_t  cgen_st_i,
   output logic [2:0]        led_o,
   output logic              cgen_sync_b_o,
   output logic              cgen_ref_sel_o,
   input  logic              pps_i,
   output logic [63:0]       vita_time_o,
   output logic              pps_int_o
);

   u1_pkg::wb_req_t    misc_req;
   u1_pkg::wb_rsp_t    misc_rsp;
   u1_pkg::wb_req_t    set_req;
   u1_pkg::wb_rsp_t    set_rsp;
   u1_pkg::set_bus_t   set_bus;
   u1_pkg::vita_time_u vita_time;

   wb_decoder u_decoder
   (
      .m_req_i    (wb_req_i),
      .m_rsp_o    (wb_rsp_o),
      .misc_req_o (misc_req),
      .misc_rsp_i (misc_rsp),
      .set_req_o  (set_req),
      .set_rsp_i  (set_rsp)
   );

   // slave 0
   misc_regs u_misc_regs
   (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .req_i          (misc_req),
      .rsp_o          (misc_rsp),
      .cgen_st_i      (cgen_st_i),
      .led_o          (led_o),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o)
   );

   // slave 5
   settings_bus_16le u_settings
   (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .req_i  (set_req),
      .rsp_o  (set_rsp),
      .set_o  (set_bus)
   );

   time_64bit #(.TICKS_PER_SEC(TICKS_PER_SEC), .BASE(u1_pkg::SR_TIME64)) u_time
   (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .set_i       (set_bus),
      .pps_i       (pps_i),
      .vita_time_o (vita_time),
      .pps_int_o   (pps_int_o)
   );

   assign vita_time_o = vita_time.raw;

endmodule

// File: sim/tb_u1_core.sv
//////////////////////////////////////////////////////////////////////
// u1_core testbench with random bus traffic against register and time models
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_u1_core;

   localparam int HALF   = 2;       // 4 ns clock
   localparam int TPS    = 20;      // ticks per second in the DUT
   localparam int N_MISC = 200;
   localparam int N_LOAD = 8;
   localparam int N_PPS  = 6;
   localparam int N_OPS  = N_MISC + N_LOAD * 8 + N_PPS * 4 + 20;

   logic              wb_clk;
   logic              wb_rst;
   u1_pkg::wb_req_t   req;
   u1_pkg::wb_rsp_t   rsp;
   u1_pkg::cgen_st_t  cgen_st;
   logic [2:0]        led;
   logic              sync_b;
   logic              ref_sel;
   logic              pps;
   logic [63:0]       vita_time;
   logic              pps_int;

   logic [31:0]       rng_state;
   int unsigned       cyc_cnt = 0;
   int unsigned       pulse_cnt = 0;
   logic [15:0]       m_leds;    // register model
   logic [15:0]       m_cgen;
   logic [15:0]       m_test;

   u1_core #(.TICKS_PER_SEC(TPS)) uut
   (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .wb_req_i       (req),
      .wb_rsp_o       (rsp),
      .cgen_st_i      (cgen_st),
      .led_o          (led),
      .cgen_sync_b_o  (sync_b),
      .cgen_ref_sel_o (ref_sel),
      .pps_i          (pps),
      .vita_time_o    (vita_time),
      .pps_int_o      (pps_int)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #HALF wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cyc_cnt <= cyc_cnt + 1;    // time base for the tick model

   always @(negedge wb_clk)
   begin
      if (pps_int === 1'b1)
         pulse_cnt <= pulse_cnt + 1;
   end

   initial
   begin
      #(N_OPS * 40 * 2 * HALF);
      $display("watchdog expired, a bus access or the test hung");
      $display("Some tests failed");
      $fatal(1, "watchdog");
   end

   //////////////////////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // seconds/ticks counter stepped n times with rollover at TPS
   function automatic logic [63:0] advance(input logic [63:0] t, input int unsigned n);
      logic [31:0] s;
      logic [31:0] k;
      s = t[63:32];
      k = t[31:0];
      for (int unsigned i = 0; i < n; i++)
      begin
         if (k == TPS - 1)
         begin
            k = '0;
            s = s + 32'd1;
         end
         else
            k = k + 32'd1;
      end
      return {s, k};
   endfunction

   function automatic logic [10:0] misc_addr(input logic [6:0] off);
      return {u1_pkg::SLV_MISC, off};
   endfunction

   function automatic logic [10:0] set_addr(input logic [7:0] r, input logic hi);
      return {u1_pkg::SLV_SETTINGS, r[4:0], hi, 1'b0};
   endfunction

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
      begin
         $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
         $display("Some tests failed");
         $fatal(1, "compare failed");
      end
   endtask

   // called on a falling edge and returns on the falling edge after the ack
   task automatic access(input logic we, input logic [10:0] adr, input logic [15:0] dat,
                         output logic [15:0] rdat);
      logic done;
      req.adr = adr;
      req.dat = dat;
      req.sel = 2'b11;
      req.we  = we;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      done    = 1'b0;
      rdat    = '0;
      while (!done)
      begin
         #1;    // response settled by mid low phase
         if (rsp.ack)
         begin
            rdat = rsp.dat;
            done = 1'b1;
         end
         @(negedge wb_clk);
      end
      req.cyc = 1'b0;
      req.stb = 1'b0;
      req.we  = 1'b0;
   endtask

   task automatic write_word(input logic [10:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      access(1'b1, adr, dat, unused);
   endtask

   task automatic read_word(input logic [10:0] adr, output logic [15:0] rdat);
      access(1'b0, adr, 16'd0, rdat);
   endtask

   // low half first and the high half fires the strobe
   task automatic write_setting(input logic [7:0] r, input logic [31:0] v);
      write_word(set_addr(r, 1'b0), v[15:0]);
      write_word(set_addr(r, 1'b1), v[31:16]);
   endtask

   task automatic expect_pins();
      logic [2:0] exp_led;
      exp_led[0] = m_leds[1];    // board permutation
      exp_led[1] = m_leds[0];
      exp_led[2] = m_leds[2];
      compare("led_o", exp_led, led);
      compare("cgen_sync_b_o", m_cgen[1], sync_b);
      compare("cgen_ref_sel_o", m_cgen[0], ref_sel);
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   initial
   begin
      logic [31:0] r;
      logic [31:0] d;
      logic [15:0] rd;
      logic [6:0]  off;
      logic [31:0] p_secs;
      logic [31:0] p_ticks;
      logic [63:0] exp_time;
      logic [63:0] base_time;
      int unsigned base_cyc;
      int unsigned n;
      int unsigned edges;
      logic        seen;

      rng_state = 32'd68;
      wb_rst    = 1'b1;
      req       = '0;
      cgen_st   = '0;
      pps       = 1'b0;
      m_leds    = 16'd0;
      m_cgen    = 16'd3;
      m_test    = 16'd0;
      edges     = 0;
      base_time = '0;
      base_cyc  = 0;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      // reset state
      expect_pins();
      compare("pps_int_o", 0, pps_int);
      compare("wb_rsp_o.ack idle", 0, rsp.ack);
      read_word(misc_addr(u1_pkg::REG_LEDS), rd);
      compare("leds readback", 16'd0, rd);
      read_word(misc_addr(u1_pkg::REG_CGEN_CTRL), rd);
      compare("cgen ctrl readback", 16'd3, rd);
      read_word(set_addr(u1_pkg::SR_TIME64, 1'b0), rd);
      compare("settings readback", 16'd0, rd);

      // misc register traffic
      for (int i = 0; i < N_MISC; i++)
      begin
         r = next_rand();
         d = next_rand();
         case (r % 6)
            0:
            begin
               write_word(misc_addr(u1_pkg::REG_LEDS), d[15:0]);
               m_leds = d[15:0];
               expect_pins();
            end
            1:
            begin
               write_word(misc_addr(u1_pkg::REG_CGEN_CTRL), d[15:0]);
               m_cgen = d[15:0];
               expect_pins();
            end
            2:
            begin
               write_word(misc_addr(u1_pkg::REG_TEST), d[15:0]);
               m_test = d[15:0];
               expect_pins();
            end
            3:
            begin
               if (d[1:0] == 2'd0)
               begin
                  read_word(misc_addr(u1_pkg::REG_LEDS), rd);
                  compare("leds readback", m_leds, rd);
               end
               else if (d[1:0] == 2'd1)
               begin
                  read_word(misc_addr(u1_pkg::REG_CGEN_CTRL), rd);
                  compare("cgen ctrl readback", m_cgen, rd);
               end
               else
               begin
                  read_word(misc_addr(u1_pkg::REG_TEST), rd);
                  compare("test readback", m_test, rd);
               end
            end
            4:
            begin
               cgen_st.status = d[2];
               cgen_st.ld     = d[1];
               cgen_st.refmon = d[0];
               read_word(misc_addr(u1_pkg::REG_CGEN_ST), rd);
               compare("cgen status readback", {13'd0, d[2], d[1], d[0]}, rd);
            end
            default:
            begin
               off = 7'(10 + d % 100);    // above every mapped offset
               read_word(misc_addr(off), rd);
               compare("unmapped readback", 16'hBEEF, rd);
            end
         endcase
      end

      //////////////////////////////////////////////////////////////////////
      // immediate load then free running with rollover
      for (int j = 0; j < N_LOAD; j++)
      begin
         p_secs  = next_rand();
         p_ticks = next_rand() % TPS;
         write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_SECS, p_secs);
         write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_TICKS, p_ticks);
         write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_LOAD, 32'd1);
         @(negedge wb_clk);    // strobe cycle
         compare("vita_time_o after load", {p_secs, p_ticks}, vita_time);
         n = next_rand() % 40;
         repeat (n) @(negedge wb_clk);
         exp_time = advance({p_secs, p_ticks}, n);
         compare("vita_time_o after run", exp_time, vita_time);
         base_time = exp_time;
         base_cyc  = cyc_cnt;
      end

      //////////////////////////////////////////////////////////////////////
      // armed load on pps
      p_secs  = next_rand();
      p_ticks = next_rand() % TPS;
      write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_SECS, p_secs);
      write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_TICKS, p_ticks);
      write_setting(u1_pkg::SR_TIME64 + u1_pkg::SR_LOAD, 32'd0);
      @(negedge wb_clk);
      n = next_rand() % 6;
      repeat (n) @(negedge wb_clk);
      compare("vita_time_o while armed", advance(base_time, cyc_cnt - base_cyc), vita_time);

      pps   = 1'b1;
      edges = edges + 1;
      seen  = 1'b0;
      for (int k = 0; k < 6 && !seen; k++)
      begin
         @(negedge wb_clk);
         seen = pps_int;
      end
      if (!seen)
      begin
         $display("no pps_int_o pulse within 6 cycles of the pps_i rising edge");
         $display("Some tests failed");
         $fatal(1, "pps timeout");
      end
      compare("vita_time_o at pps load", {p_secs, p_ticks}, vita_time);
      pps = 1'b0;

      // more pps edges with random gaps and one pulse each
      for (int k = 0; k < N_PPS; k++)
      begin
         n = 3 + next_rand() % 6;
         repeat (n) @(negedge wb_clk);
         pps   = 1'b1;
         edges = edges + 1;
         n = 1 + next_rand() % 3;
         repeat (n) @(negedge wb_clk);
         pps = 1'b0;
      end
      repeat (6) @(negedge wb_clk);
      compare("pps_int_o pulse count", edges, pulse_cnt);

      $display("All tests passed");
      $finish;
   end

endmodule

// File: list.f
rtl/u1_pkg.sv
rtl/wb_decoder.sv
rtl/misc_regs.sv
rtl/settings_bus_16le.sv
rtl/time_64bit.sv
rtl/u1_core.sv
sim/tb_u1_core.sv
